//--- src/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// SRAM chip geometry
`define MEM_ADDR_W 18
`define MEM_DATA_W 16

// Phase length field and its reset value
`define WAIT_W 4
`define DEF_WAIT 1

// APB register map
`define APB_ADDR_W 4
`define REG_CTRL 0
`define REG_STAT 4

// Per-port access counters
`define CNT_W 16

`endif

//--- src/mem_pkg.sv
`include "mem_settings.svh"

package mem_pkg;

	////////////////////////////////////////////////////////////
	// Controller FSM
	////////////////////////////////////////////////////////////

	// One access walks SETUP, STROBE, FINISH
	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		SETUP  = 2'd1,
		STROBE = 2'd2,
		FINISH = 2'd3
	} sram_state_e;

	////////////////////////////////////////////////////////////
	// Configuration from the register block
	////////////////////////////////////////////////////////////

	// Same bit order as the CTRL register
	typedef struct packed {
		logic [`WAIT_W-1:0] wait_cnt;
		logic               en;
	} sram_cfg_t;

endpackage

//--- src/mem_req_if.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

interface mem_req_if;

	// Request side, held stable until done
	logic                   req;
	logic                   we;
	logic [`MEM_ADDR_W-1:0] addr;
	logic [`MEM_DATA_W-1:0] wdata;

	// Completion side
	logic [`MEM_DATA_W-1:0] rdata;
	logic                   done;

	modport requester (
		output req, we, addr, wdata,
		input  rdata, done
	);

	modport controller (
		input  req, we, addr, wdata,
		output rdata, done
	);

endinterface

//--- src/sram_cfg_regs.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module sram_cfg_regs (
	input  logic                   clk,
	input  logic                   rst,

	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`APB_ADDR_W-1:0] paddr,
	input  logic [31:0]            pwdata,
	output logic [31:0]            prdata,
	output logic                   pready,

	output mem_pkg::sram_cfg_t     cfg,
	input  logic                   fetch_hit,
	input  logic                   exec_hit
);

	localparam logic [`APB_ADDR_W-1:0] CTRL_OFS = `APB_ADDR_W'(`REG_CTRL);
	localparam logic [`APB_ADDR_W-1:0] STAT_OFS = `APB_ADDR_W'(`REG_STAT);

	logic              wr_en;
	logic              stat_clr;
	logic [`CNT_W-1:0] fetch_cnt;
	logic [`CNT_W-1:0] exec_cnt;

	// Counters stick at all ones
	function automatic logic [`CNT_W-1:0] sat_inc(input logic [`CNT_W-1:0] v, input logic hit);
		return (hit && v != '1) ? v + 1'b1 : v;
	endfunction

	// No wait states
	assign pready   = 1'b1;
	assign wr_en    = psel & penable & pwrite;
	assign stat_clr = wr_en && (paddr == STAT_OFS);

	////////////////////////////////////////////////////////////
	// CTRL register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cfg <= {`WAIT_W'(`DEF_WAIT), 1'b1};
		end else if (wr_en && paddr == CTRL_OFS) begin
			cfg <= pwdata[`WAIT_W:0];
		end
	end

	////////////////////////////////////////////////////////////
	// Access counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			fetch_cnt <= '0;
			exec_cnt  <= '0;
		end else if (stat_clr) begin
			fetch_cnt <= '0;
			exec_cnt  <= '0;
		end else begin
			fetch_cnt <= sat_inc(fetch_cnt, fetch_hit);
			exec_cnt  <= sat_inc(exec_cnt, exec_hit);
		end
	end

	// Read mux
	always_comb begin
		prdata = '0;
		if (psel) begin
			case (paddr)
				CTRL_OFS: prdata[`WAIT_W:0] = cfg;
				STAT_OFS: prdata = {exec_cnt, fetch_cnt};
				default:  prdata = '0;
			endcase
		end
	end

endmodule

//--- src/sram_port_ctrl.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module sram_port_ctrl (
	input  logic                   clk,
	input  logic                   rst,

	mem_req_if.controller          fetch,
	mem_req_if.controller          exec,

	input  mem_pkg::sram_cfg_t     cfg,
	output logic                   fetch_hit,
	output logic                   exec_hit,

	output logic [`MEM_ADDR_W-1:0] sram_addr,
	output logic                   sram_ce_n,
	output logic                   sram_oe_n,
	output logic                   sram_we_n,
	inout  wire  [`MEM_DATA_W-1:0] sram_data
);

	import mem_pkg::*;

	sram_state_e            state;
	sram_state_e            next_state;
	logic [`WAIT_W-1:0]     phase_cnt;
	logic [`WAIT_W-1:0]     wait_q;
	logic                   sel_exec;
	logic                   we_q;
	logic                   done_q;

	logic [`MEM_ADDR_W-1:0] addr_q;
	logic [`MEM_DATA_W-1:0] wdata_q;
	logic [`MEM_DATA_W-1:0] fetch_rdata_q;
	logic [`MEM_DATA_W-1:0] exec_rdata_q;

	logic                   take_exec;
	logic                   accept;
	logic                   phase_end;
	logic                   fetch_done;
	logic                   exec_done;

	////////////////////////////////////////////////////////////
	// Arbitration
	////////////////////////////////////////////////////////////

	// Execute has priority
	assign take_exec = exec.req;

	// Done cycle blocks a re-accept of the same request
	assign accept = (state == IDLE) && !done_q && cfg.en && (exec.req || fetch.req);

	assign phase_end = (phase_cnt == wait_q);

	always_comb begin
		case (state)
			IDLE:    next_state = SETUP;
			SETUP:   next_state = STROBE;
			STROBE:  next_state = FINISH;
			default: next_state = IDLE;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Phase FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state     <= IDLE;
			phase_cnt <= '0;
			wait_q    <= '0;
			sel_exec  <= 1'b0;
			we_q      <= 1'b0;
			done_q    <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (state == IDLE) begin
				if (accept) begin
					state     <= next_state;
					phase_cnt <= '0;
					wait_q    <= cfg.wait_cnt;
					sel_exec  <= take_exec;
					we_q      <= take_exec & exec.we;
				end
			end else if (phase_end) begin
				state     <= next_state;
				phase_cnt <= '0;
				done_q    <= (state == FINISH);
			end else begin
				phase_cnt <= phase_cnt + 1'b1;
			end
		end
	end

	// Address, write data and read results
	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q  <= take_exec ? exec.addr : fetch.addr;
			wdata_q <= exec.wdata;
		end
		if (state == STROBE && phase_end && !we_q) begin
			if (sel_exec) begin
				exec_rdata_q <= sram_data;
			end else begin
				fetch_rdata_q <= sram_data;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// SRAM pins
	////////////////////////////////////////////////////////////

	assign sram_addr = addr_q;
	assign sram_ce_n = (state == IDLE);
	assign sram_oe_n = !(state == STROBE && !we_q);
	assign sram_we_n = !(state == STROBE && we_q);

	// Write data spans SETUP through FINISH
	assign sram_data = (we_q && state != IDLE) ? wdata_q : 'z;

	// Completion back to the requesters
	assign fetch_done  = done_q & ~sel_exec;
	assign exec_done   = done_q & sel_exec;
	assign fetch.done  = fetch_done;
	assign exec.done   = exec_done;
	assign fetch.rdata = fetch_rdata_q;
	assign exec.rdata  = exec_rdata_q;
	assign fetch_hit   = fetch_done;
	assign exec_hit    = exec_done;

endmodule

//--- src/sram_subsys.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module sram_subsys (
	input  logic                   clk,
	input  logic                   rst,

	input  logic                   fetch_req,
	input  logic [`MEM_ADDR_W-1:0] fetch_addr,
	output logic [`MEM_DATA_W-1:0] fetch_rdata,
	output logic                   fetch_done,

	input  logic                   exec_req,
	input  logic                   exec_we,
	input  logic [`MEM_ADDR_W-1:0] exec_addr,
	input  logic [`MEM_DATA_W-1:0] exec_wdata,
	output logic [`MEM_DATA_W-1:0] exec_rdata,
	output logic                   exec_done,

	output logic [`MEM_ADDR_W-1:0] sram_addr,
	output logic                   sram_ce_n,
	output logic                   sram_oe_n,
	output logic                   sram_we_n,
	inout  wire  [`MEM_DATA_W-1:0] sram_data,

	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`APB_ADDR_W-1:0] paddr,
	input  logic [31:0]            pwdata,
	output logic [31:0]            prdata,
	output logic                   pready
);

	import mem_pkg::*;

	sram_cfg_t cfg;
	logic      fetch_hit;
	logic      exec_hit;

	mem_req_if fetch_bus ();
	mem_req_if exec_bus ();

	// Fetch port is read only
	assign fetch_bus.req  = fetch_req;
	assign fetch_bus.addr = fetch_addr;
	assign fetch_rdata    = fetch_bus.rdata;
	assign fetch_done     = fetch_bus.done;

	assign exec_bus.req   = exec_req;
	assign exec_bus.we    = exec_we;
	assign exec_bus.addr  = exec_addr;
	assign exec_bus.wdata = exec_wdata;
	assign exec_rdata     = exec_bus.rdata;
	assign exec_done      = exec_bus.done;

	sram_cfg_regs cfg_regs_i (
		.clk       (clk),
		.rst       (rst),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.cfg       (cfg),
		.fetch_hit (fetch_hit),
		.exec_hit  (exec_hit)
	);

	sram_port_ctrl port_ctrl_i (
		.clk       (clk),
		.rst       (rst),
		.fetch     (fetch_bus),
		.exec      (exec_bus),
		.cfg       (cfg),
		.fetch_hit (fetch_hit),
		.exec_hit  (exec_hit),
		.sram_addr (sram_addr),
		.sram_ce_n (sram_ce_n),
		.sram_oe_n (sram_oe_n),
		.sram_we_n (sram_we_n),
		.sram_data (sram_data)
	);

endmodule

//--- test/sram_model.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module sram_model (
	input  logic [`MEM_ADDR_W-1:0] addr,
	input  logic                   ce_n,
	input  logic                   oe_n,
	input  logic                   we_n,
	inout  wire  [`MEM_DATA_W-1:0] data
);

	logic [`MEM_DATA_W-1:0] mem [0:(1 << `MEM_ADDR_W)-1];

	// Power-up contents follow the full address
	initial begin
		for (int i = 0; i < (1 << `MEM_ADDR_W); i++) begin
			mem[i] = `MEM_DATA_W'(i) ^ `MEM_DATA_W'(i >> 16) ^ 16'hc3a5;
		end
	end

	// Read drives the bus while output enable is low
	assign data = (ce_n == 1'b0 && oe_n == 1'b0 && we_n == 1'b1) ? mem[addr] : 'z;

	// Write lands on the rising edge of we_n
	always @(posedge we_n) begin
		if (ce_n === 1'b0) begin
			mem[addr] <= data;
		end
	end

endmodule

//--- test/sram_subsys_props.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module sram_subsys_props (
	input logic               clk,
	input logic               rst,
	input logic               sram_ce_n,
	input logic               sram_oe_n,
	input logic               sram_we_n,
	input logic               fetch_done,
	input logic               exec_done,
	input mem_pkg::sram_cfg_t cfg
);

	localparam logic [`WAIT_W:0] ONE = 1;

	int                 fail_cnt = 0;
	logic               strobe;
	logic [`WAIT_W:0]   low_cnt;
	logic [`WAIT_W-1:0] wait_lat;

	// Either strobe pin active
	assign strobe = !sram_oe_n || !sram_we_n;

	// Strobe length so far and the wait count it runs under
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			low_cnt  <= '0;
			wait_lat <= '0;
		end else if (strobe) begin
			low_cnt <= low_cnt + ONE;
			if (low_cnt == '0) begin
				wait_lat <= cfg.wait_cnt;
			end
		end else begin
			low_cnt <= '0;
		end
	end

	no_double_strobe: assert property (@(posedge clk) disable iff (!rst)
		!(!sram_oe_n && !sram_we_n))
		else begin
			fail_cnt++;
			$error("oe_n and we_n are low in the same cycle");
		end

	write_needs_ce: assert property (@(posedge clk) disable iff (!rst)
		!sram_we_n |-> !sram_ce_n)
		else begin
			fail_cnt++;
			$error("we_n is low while ce_n is high");
		end

	strobe_width: assert property (@(posedge clk) disable iff (!rst)
		$fell(strobe) |-> low_cnt == {1'b0, wait_lat} + ONE)
		else begin
			fail_cnt++;
			$error("strobe width is not wait+1 cycles");
		end

	fetch_done_pulse: assert property (@(posedge clk) disable iff (!rst)
		fetch_done |=> !fetch_done)
		else begin
			fail_cnt++;
			$error("fetch_done is longer than one cycle");
		end

	exec_done_pulse: assert property (@(posedge clk) disable iff (!rst)
		exec_done |=> !exec_done)
		else begin
			fail_cnt++;
			$error("exec_done is longer than one cycle");
		end

endmodule

//--- test/sram_subsys_tb.sv
`timescale 1ns/1ps
`include "mem_settings.svh"

module sram_subsys_tb;

	localparam int CYCLE_LIMIT = 3000;
	localparam int N_RAND      = 8;
	localparam logic [`APB_ADDR_W-1:0] CTRL = `APB_ADDR_W'(`REG_CTRL);
	localparam logic [`APB_ADDR_W-1:0] STAT = `APB_ADDR_W'(`REG_STAT);

	logic                   clk;
	logic                   rst;
	logic                   fetch_req;
	logic [`MEM_ADDR_W-1:0] fetch_addr;
	logic [`MEM_DATA_W-1:0] fetch_rdata;
	logic                   fetch_done;
	logic                   exec_req;
	logic                   exec_we;
	logic [`MEM_ADDR_W-1:0] exec_addr;
	logic [`MEM_DATA_W-1:0] exec_wdata;
	logic [`MEM_DATA_W-1:0] exec_rdata;
	logic                   exec_done;
	logic [`MEM_ADDR_W-1:0] sram_addr;
	logic                   sram_ce_n;
	logic                   sram_oe_n;
	logic                   sram_we_n;
	wire  [`MEM_DATA_W-1:0] sram_data;
	logic                   psel;
	logic                   penable;
	logic                   pwrite;
	logic [`APB_ADDR_W-1:0] paddr;
	logic [31:0]            pwdata;
	logic [31:0]            prdata;
	logic                   pready;

	int errors     = 0;
	int checks     = 0;
	int cycles     = 0;
	int fetch_seen = 0;
	int exec_seen  = 0;

	logic [`MEM_DATA_W-1:0] ref_mem [logic [`MEM_ADDR_W-1:0]];
	logic [`MEM_ADDR_W-1:0] addr_list [$];

	sram_subsys sram_subsys_i (.*);

	sram_model sram_model_i (
		.addr (sram_addr),
		.ce_n (sram_ce_n),
		.oe_n (sram_oe_n),
		.we_n (sram_we_n),
		.data (sram_data)
	);

	bind sram_subsys sram_subsys_props props_i (
		.clk        (clk),
		.rst        (rst),
		.sram_ce_n  (sram_ce_n),
		.sram_oe_n  (sram_oe_n),
		.sram_we_n  (sram_we_n),
		.fetch_done (fetch_done),
		.exec_done  (exec_done),
		.cfg        (cfg)
	);

	always #5 clk = ~clk;

	// Cycle count, done pulse count and run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (fetch_done) fetch_seen <= fetch_seen + 1;
		if (exec_done) exec_seen <= exec_seen + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Bus tasks
	////////////////////////////////////////////////////////////

	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic expect_equal(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("CHECK FAILED at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic apb_write(input logic [`APB_ADDR_W-1:0] a, input logic [31:0] d);
		psel    = 1'b1;
		pwrite  = 1'b1;
		paddr   = a;
		pwdata  = d;
		tick();
		penable = 1'b1;
		expect_equal("pready on write", 32'(pready), 32'd1);
		tick();
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input logic [`APB_ADDR_W-1:0] a, output logic [31:0] d);
		psel    = 1'b1;
		paddr   = a;
		tick();
		penable = 1'b1;
		#2;
		d = prdata;
		expect_equal("pready on read", 32'(pready), 32'd1);
		tick();
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic run_exec(input logic we, input logic [`MEM_ADDR_W-1:0] a,
			input logic [`MEM_DATA_W-1:0] d, output logic [`MEM_DATA_W-1:0] q);
		exec_req   = 1'b1;
		exec_we    = we;
		exec_addr  = a;
		exec_wdata = d;
		do begin
			tick();
		end while (!exec_done);
		q        = exec_rdata;
		exec_req = 1'b0;
		exec_we  = 1'b0;
		if (we) ref_mem[a] = d;
	endtask

	task automatic run_fetch(input logic [`MEM_ADDR_W-1:0] a,
			output logic [`MEM_DATA_W-1:0] q);
		fetch_req  = 1'b1;
		fetch_addr = a;
		do begin
			tick();
		end while (!fetch_done);
		q         = fetch_rdata;
		fetch_req = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////

	initial begin
		logic [`MEM_DATA_W-1:0] q;
		logic [`MEM_ADDR_W-1:0] a;
		logic [31:0]            r;
		int                     f_cycle;
		int                     e_cycle;
		int                     base_f;
		int                     base_e;

		void'($urandom(96152));
		clk        = 1'b0;
		rst        = 1'b0;
		fetch_req  = 1'b0;
		fetch_addr = '0;
		exec_req   = 1'b0;
		exec_we    = 1'b0;
		exec_addr  = '0;
		exec_wdata = '0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		repeat (2) @(posedge clk);
		#1 rst = 1'b1;
		tick();

		// Random writes, then reads back from both ports
		for (int i = 0; i < N_RAND; i++) begin
			a = `MEM_ADDR_W'($urandom);
			run_exec(1'b1, a, `MEM_DATA_W'($urandom), q);
			addr_list.push_back(a);
		end
		foreach (addr_list[i]) begin
			run_fetch(addr_list[i], q);
			expect_equal("fetch read", 32'(q), 32'(ref_mem[addr_list[i]]));
			run_exec(1'b0, addr_list[i], '0, q);
			expect_equal("exec read", 32'(q), 32'(ref_mem[addr_list[i]]));
		end

		// Counters match the pulses, then clear
		apb_read(STAT, r);
		expect_equal("STAT counts", r, {`CNT_W'(exec_seen), `CNT_W'(fetch_seen)});
		apb_write(STAT, 32'h0);
		apb_read(STAT, r);
		expect_equal("STAT after clear", r, 32'h0);
		base_f = fetch_seen;
		base_e = exec_seen;

		// Both ports at once, execute goes first
		fetch_addr = addr_list[1];
		exec_addr  = addr_list[2];
		fetch_req  = 1'b1;
		exec_req   = 1'b1;
		f_cycle    = 0;
		e_cycle    = 0;
		while (fetch_req || exec_req) begin
			tick();
			if (exec_done && exec_req) begin
				e_cycle  = cycles;
				exec_req = 1'b0;
				expect_equal("race exec read", 32'(exec_rdata), 32'(ref_mem[addr_list[2]]));
			end
			if (fetch_done && fetch_req) begin
				f_cycle   = cycles;
				fetch_req = 1'b0;
				expect_equal("race fetch read", 32'(fetch_rdata), 32'(ref_mem[addr_list[1]]));
			end
		end
		expect_equal("exec done before fetch done", 32'(e_cycle < f_cycle), 32'd1);

		// Disabled controller holds a pending fetch
		apb_write(CTRL, 32'h2);
		apb_read(CTRL, r);
		expect_equal("CTRL readback", r, 32'h2);
		fetch_addr = addr_list[3];
		fetch_req  = 1'b1;
		repeat (60) begin
			tick();
			expect_equal("no done while disabled", 32'(fetch_done), 32'd0);
		end
		apb_write(CTRL, 32'h3);
		do begin
			tick();
		end while (!fetch_done);
		fetch_req = 1'b0;
		expect_equal("fetch after enable", 32'(fetch_rdata), 32'(ref_mem[addr_list[3]]));

		// Longer phases, wait count 5
		apb_write(CTRL, 32'hb);
		apb_read(CTRL, r);
		expect_equal("CTRL readback", r, 32'hb);
		for (int i = 0; i < 4; i++) begin
			run_exec(1'b1, addr_list[i], `MEM_DATA_W'($urandom), q);
			run_fetch(addr_list[i], q);
			expect_equal("fetch read, wait 5", 32'(q), 32'(ref_mem[addr_list[i]]));
		end
		apb_read(STAT, r);
		expect_equal("STAT counts", r,
			{`CNT_W'(exec_seen - base_e), `CNT_W'(fetch_seen - base_f)});

		errors += sram_subsys_i.props_i.fail_cnt;
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- all.f
+incdir+src
src/mem_pkg.sv
src/mem_req_if.sv
src/sram_cfg_regs.sv
src/sram_port_ctrl.sv
src/sram_subsys.sv
test/sram_model.sv
test/sram_subsys_props.sv
test/sram_subsys_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= sram_subsys_tb
FLAGS     ?= --binary --timing --assert
BUILD     ?= obj_dir

.PHONY: sim clean

# Build, run, and pass only if the pass line shows up
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f all.f
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf $(BUILD)
